// ==== screenPkg.sv ====
package screenPkg;

    // playfield geometry
    localparam int CoordWidth   = 10;
    localparam int ScreenWidth  = 640;
    localparam int ScreenHeight = 480;

    typedef logic [CoordWidth-1:0] coord_t;
    typedef logic signed [CoordWidth:0] diff_t;

    // wide enough for the sum of two squared signed differences
    typedef logic [2*CoordWidth+1:0] dist_t;

    // squared euclidean distance between two points
    function automatic dist_t distSq(
        input coord_t ax,
        input coord_t ay,
        input coord_t bx,
        input coord_t by
    );
        diff_t dx;
        diff_t dy;
        logic signed [2*CoordWidth+1:0] sum;
        dx = diff_t'({1'b0, ax}) - diff_t'({1'b0, bx});
        dy = diff_t'({1'b0, ay}) - diff_t'({1'b0, by});
        sum = dx * dx + dy * dy;
        return dist_t'(sum);
    endfunction

endpackage

// ==== dotPkg.sv ====
package dotPkg;

    localparam int DotCount  = 16;
    // dots below this index make the player grow, the rest shrink it
    localparam int GrowCount = 8;

    localparam int DotRadius    = 4;
    localparam int PlayerRadius = 4;

    typedef logic [3:0] size_t;

    localparam size_t SizeInit = 4'd4;
    localparam size_t SizeMin  = 4'd1;
    localparam size_t SizeMax  = 4'd10;

    // random bits kept when a dot respawns
    localparam int RespawnXBits = 9;
    localparam int RespawnYBits = 8;

    // reset positions with dot 15 just off the right edge
    localparam screenPkg::coord_t SeedX [DotCount] = '{
        10'd150, 10'd12,  10'd17,  10'd45,
        10'd66,  10'd77,  10'd89,  10'd100,
        10'd200, 10'd300, 10'd400, 10'd455,
        10'd543, 10'd602, 10'd625, 10'd644
    };

    localparam screenPkg::coord_t SeedY [DotCount] = '{
        10'd300, 10'd7,   10'd58,  10'd69,
        10'd88,  10'd92,  10'd120, 10'd130,
        10'd66,  10'd99,  10'd89,  10'd300,
        10'd400, 10'd38,  10'd5,   10'd79
    };

    // one size decision per frame tick
    typedef enum logic [1:0] {
        HitNone,
        HitGrow,
        HitShrink
    } hitKind_t;

endpackage

// ==== collisionScan.sv ====
`timescale 1ns/100ps

module collisionScan (
    input  logic               Clk,
    input  logic               rst,
    input  logic               frameClk,
    input  screenPkg::coord_t  playerX,
    input  screenPkg::coord_t  playerY,
    input  screenPkg::coord_t  dotX [dotPkg::DotCount],
    input  screenPkg::coord_t  dotY [dotPkg::DotCount],
    input  dotPkg::size_t      playerSize,
    output logic               frameTick,
    output logic               hitMask [dotPkg::DotCount],
    output dotPkg::hitKind_t   hitKind,
    output logic               growHit,
    output logic               shrinkHit
);

    logic              frameSample;
    logic [4:0]        reach;
    screenPkg::dist_t  reachSq;

    // previous level of the frame strobe
    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            frameSample <= 1'b0;
        end
        else
        begin
            frameSample <= frameClk;
        end
    end

    // one cycle pulse on the rising edge
    assign frameTick = frameClk && !frameSample;

    // player radius grows with its size
    assign reach   = 5'(dotPkg::PlayerRadius) + 5'(playerSize);
    assign reachSq = screenPkg::dist_t'(reach) * screenPkg::dist_t'(reach);

    always_comb
    begin
        growHit   = 1'b0;
        shrinkHit = 1'b0;
        for (int i = 0; i < dotPkg::DotCount; i++)
        begin
            hitMask[i] = screenPkg::distSq(playerX, playerY, dotX[i], dotY[i]) <= reachSq;
            if (hitMask[i])
            begin
                if (i < dotPkg::GrowCount)
                begin
                    growHit = 1'b1;
                end
                else
                begin
                    shrinkHit = 1'b1;
                end
            end
        end
    end

    // grow wins when both kinds are touched
    always_comb
    begin
        if (growHit)
        begin
            hitKind = dotPkg::HitGrow;
        end
        else if (shrinkHit)
        begin
            hitKind = dotPkg::HitShrink;
        end
        else
        begin
            hitKind = dotPkg::HitNone;
        end
    end

endmodule

// ==== dotField.sv ====
`timescale 1ns/100ps

module dotField (
    input  logic               Clk,
    input  logic               rst,
    input  logic               frameTick,
    input  logic               hitMask [dotPkg::DotCount],
    input  dotPkg::hitKind_t   hitKind,
    input  screenPkg::coord_t  randX,
    input  screenPkg::coord_t  randY,
    output screenPkg::coord_t  dotX [dotPkg::DotCount],
    output screenPkg::coord_t  dotY [dotPkg::DotCount],
    output dotPkg::size_t      playerSize
);

    screenPkg::coord_t respawnX;
    screenPkg::coord_t respawnY;

    // keep respawns inside the left and upper part of the field
    assign respawnX = screenPkg::coord_t'(randX[dotPkg::RespawnXBits-1:0]);
    assign respawnY = screenPkg::coord_t'(randY[dotPkg::RespawnYBits-1:0]);

    // dot positions
    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < dotPkg::DotCount; i++)
            begin
                dotX[i] <= dotPkg::SeedX[i];
                dotY[i] <= dotPkg::SeedY[i];
            end
        end
        else if (frameTick)
        begin
            // every dot hit this tick lands on the same spot
            for (int i = 0; i < dotPkg::DotCount; i++)
            begin
                if (hitMask[i])
                begin
                    dotX[i] <= respawnX;
                    dotY[i] <= respawnY;
                end
            end
        end
    end

    // player size clamped at both ends
    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            playerSize <= dotPkg::SizeInit;
        end
        else if (frameTick)
        begin
            case (hitKind)
                dotPkg::HitGrow:
                begin
                    if (playerSize != dotPkg::SizeMax)
                    begin
                        playerSize <= playerSize + 4'd1;
                    end
                end
                dotPkg::HitShrink:
                begin
                    if (playerSize != dotPkg::SizeMin)
                    begin
                        playerSize <= playerSize - 4'd1;
                    end
                end
                default:
                begin
                    playerSize <= playerSize;
                end
            endcase
        end
    end

endmodule

// ==== dotRenderer.sv ====
`timescale 1ns/100ps

module dotRenderer (
    input  logic               Clk,
    input  logic               rst,
    input  screenPkg::coord_t  drawX,
    input  screenPkg::coord_t  drawY,
    input  screenPkg::coord_t  dotX [dotPkg::DotCount],
    input  screenPkg::coord_t  dotY [dotPkg::DotCount],
    output logic               dotPixel [dotPkg::DotCount]
);

    logic onScreen;

    // nothing is drawn outside the visible area
    assign onScreen = (drawX < screenPkg::ScreenWidth) && (drawY < screenPkg::ScreenHeight);

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < dotPkg::DotCount; i++)
            begin
                dotPixel[i] <= 1'b0;
            end
        end
        else
        begin
            // pixel inside the dot's circle
            for (int i = 0; i < dotPkg::DotCount; i++)
            begin
                dotPixel[i] <= onScreen
                    && (screenPkg::distSq(drawX, drawY, dotX[i], dotY[i])
                        <= screenPkg::dist_t'(dotPkg::DotRadius * dotPkg::DotRadius));
            end
        end
    end

endmodule

// ==== foodDots.sv ====
`timescale 1ns/100ps

module foodDots (
    input  logic               Clk,
    input  logic               rst,
    input  logic               frameClk,
    input  screenPkg::coord_t  playerX,
    input  screenPkg::coord_t  playerY,
    input  screenPkg::coord_t  randX,
    input  screenPkg::coord_t  randY,
    input  screenPkg::coord_t  drawX,
    input  screenPkg::coord_t  drawY,
    output logic               growHit,
    output logic               shrinkHit,
    output logic               dotPixel [dotPkg::DotCount],
    output dotPkg::size_t      playerSize
);

    logic              frameTick;
    logic              hitMask [dotPkg::DotCount];
    dotPkg::hitKind_t  hitKind;
    screenPkg::coord_t dotX [dotPkg::DotCount];
    screenPkg::coord_t dotY [dotPkg::DotCount];

    // frame edge and player collisions
    collisionScan scan (
        .Clk        (Clk),
        .rst        (rst),
        .frameClk   (frameClk),
        .playerX    (playerX),
        .playerY    (playerY),
        .dotX       (dotX),
        .dotY       (dotY),
        .playerSize (playerSize),
        .frameTick  (frameTick),
        .hitMask    (hitMask),
        .hitKind    (hitKind),
        .growHit    (growHit),
        .shrinkHit  (shrinkHit)
    );

    dotField field (
        .Clk        (Clk),
        .rst        (rst),
        .frameTick  (frameTick),
        .hitMask    (hitMask),
        .hitKind    (hitKind),
        .randX      (randX),
        .randY      (randY),
        .dotX       (dotX),
        .dotY       (dotY),
        .playerSize (playerSize)
    );

    // per-dot pixel test one cycle behind the draw position
    dotRenderer render (
        .Clk      (Clk),
        .rst      (rst),
        .drawX    (drawX),
        .drawY    (drawY),
        .dotX     (dotX),
        .dotY     (dotY),
        .dotPixel (dotPixel)
    );

endmodule

// ==== foodDotsTb.sv ====
`timescale 1ns/100ps

module foodDotsTb;

    logic              Clk;
    logic              rst;
    logic              frameClk;
    screenPkg::coord_t playerX;
    screenPkg::coord_t playerY;
    screenPkg::coord_t randX;
    screenPkg::coord_t randY;
    screenPkg::coord_t drawX;
    screenPkg::coord_t drawY;
    logic              growHit;
    logic              shrinkHit;
    logic              dotPixel [dotPkg::DotCount];
    dotPkg::size_t     playerSize;

    // reference state and staged inputs
    screenPkg::coord_t refX [dotPkg::DotCount];
    screenPkg::coord_t refY [dotPkg::DotCount];
    int                refSize;
    screenPkg::coord_t nextPX;
    screenPkg::coord_t nextPY;
    screenPkg::coord_t nextDX;
    screenPkg::coord_t nextDY;
    screenPkg::coord_t nextRX;
    screenPkg::coord_t nextRY;
    logic              lastFc;
    logic              checkArm;
    logic              expGrow;
    logic              expShrink;
    int                expSize;
    logic [15:0]       expPix;
    logic [15:0]       actPix;
    string             testName;

    foodDots uut (
        .Clk        (Clk),
        .rst        (rst),
        .frameClk   (frameClk),
        .playerX    (playerX),
        .playerY    (playerY),
        .randX      (randX),
        .randY      (randY),
        .drawX      (drawX),
        .drawY      (drawY),
        .growHit    (growHit),
        .shrinkHit  (shrinkHit),
        .dotPixel   (dotPixel),
        .playerSize (playerSize)
    );

    initial
    begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    always_comb
    begin
        for (int i = 0; i < dotPkg::DotCount; i++)
        begin
            actPix[i] = dotPixel[i];
        end
    end

    // returns {grow, shrink, player hit per dot, pixel hit per dot}
    function automatic logic [33:0] refModel(input screenPkg::coord_t px,
        input screenPkg::coord_t py, input screenPkg::coord_t qx, input screenPkg::coord_t qy);
        logic [33:0] res;
        int dx;
        int dy;
        int reach;
        res = '0;
        reach = 4 + refSize;
        for (int i = 0; i < dotPkg::DotCount; i++)
        begin
            dx = int'(px) - int'(refX[i]);
            dy = int'(py) - int'(refY[i]);
            if (dx * dx + dy * dy <= reach * reach)
            begin
                res[16 + i] = 1'b1;
                // dots 0 to 7 grow, 8 to 15 shrink
                res[i < 8 ? 33 : 32] = 1'b1;
            end
            dx = int'(qx) - int'(refX[i]);
            dy = int'(qy) - int'(refY[i]);
            res[i] = (qx < 640) && (qy < 480) && (dx * dx + dy * dy <= 16);
        end
        return res;
    endfunction

    function automatic screenPkg::coord_t jitter(input screenPkg::coord_t c);
        return c + 10'($urandom_range(12, 0)) - 10'd6;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkEq(input string name, input logic [31:0] expVal, input logic [31:0] actVal);
        if (expVal !== actVal)
        begin
            failRun($sformatf("[FAIL] %s expected 0x%0h actual 0x%0h", name, expVal, actVal));
        end
    endtask

    // outputs settle well before the next falling edge
    always @(posedge Clk)
    begin
        #1;
        if (checkArm)
        begin
            checkEq({testName, " growHit"}, expGrow, growHit);
            checkEq({testName, " shrinkHit"}, expShrink, shrinkHit);
            checkEq({testName, " playerSize"}, expSize, playerSize);
            checkEq({testName, " dotPixel"}, expPix, actPix);
        end
    end

    task automatic setPlayer(input screenPkg::coord_t x, input screenPkg::coord_t y);
        nextPX = x;
        nextPY = y;
    endtask

    task automatic setDraw(input screenPkg::coord_t x, input screenPkg::coord_t y);
        nextDX = x;
        nextDY = y;
    endtask

    task automatic setRand(input screenPkg::coord_t x, input screenPkg::coord_t y);
        nextRX = x;
        nextRY = y;
    endtask

    // drive one clock on the falling edge and advance the reference model
    task automatic cycle(input logic fc);
        logic [33:0] pre;
        logic [33:0] post;
        @(negedge Clk);
        frameClk = fc;
        playerX = nextPX;
        playerY = nextPY;
        drawX = nextDX;
        drawY = nextDY;
        randX = nextRX;
        randY = nextRY;
        pre = refModel(nextPX, nextPY, nextDX, nextDY);
        expPix = pre[15:0];
        if (fc && !lastFc)
        begin
            for (int i = 0; i < dotPkg::DotCount; i++)
            begin
                if (pre[16 + i])
                begin
                    refX[i] = nextRX & 10'h1ff;
                    refY[i] = nextRY & 10'h0ff;
                end
            end
            if (pre[33])
            begin
                refSize = (refSize < 10) ? refSize + 1 : refSize;
            end
            else if (pre[32])
            begin
                refSize = (refSize > 1) ? refSize - 1 : refSize;
            end
        end
        lastFc = fc;
        post = refModel(nextPX, nextPY, nextDX, nextDY);
        expGrow = post[33];
        expShrink = post[32];
        expSize = refSize;
        checkArm = 1'b1;
        @(posedge Clk);
        #1;
    endtask

    task automatic pulseFrame();
        repeat (3) cycle(1'b1);
        cycle(1'b0);
    endtask

    task automatic scanSeeds();
        for (int i = 0; i < dotPkg::DotCount; i++)
        begin
            setDraw(dotPkg::SeedX[i], dotPkg::SeedY[i]);
            cycle(1'b0);
            checkEq($sformatf("%s seed pixel %0d", testName, i), i != 15, dotPixel[i]);
        end
    endtask

    task automatic hitUntilSize(input int dotIdx, input int target);
        int tries;
        tries = 0;
        while (playerSize != target && tries < 30)
        begin
            setPlayer(refX[dotIdx], refY[dotIdx]);
            pulseFrame();
            tries++;
        end
        if (playerSize != target)
        begin
            failRun($sformatf("%s: player size never reached %0d", testName, target));
        end
    endtask

    initial
    begin
        int k;
        void'($urandom(59913));
        rst = 1'b1;
        frameClk = 1'b0;
        playerX = '0;
        playerY = '0;
        randX = '0;
        randY = '0;
        drawX = '0;
        drawY = '0;
        checkArm = 1'b0;
        lastFc = 1'b0;
        testName = "reset";
        refSize = 4;
        for (int i = 0; i < dotPkg::DotCount; i++)
        begin
            refX[i] = dotPkg::SeedX[i];
            refY[i] = dotPkg::SeedY[i];
        end
        setPlayer(10'd1000, 10'd1000);
        setDraw(10'd1000, 10'd1000);
        setRand(10'd0, 10'd0);
        repeat (8) @(posedge Clk);
        @(negedge Clk);
        rst = 1'b0;
        checkEq("reset size", 4, playerSize);
        scanSeeds();

        testName = "quiet tick";
        pulseFrame();
        checkEq("quiet size", 4, playerSize);
        scanSeeds();

        testName = "grow hit";
        setPlayer(10'd17, 10'd58);
        setDraw(10'd1000, 10'd1000);
        cycle(1'b0);
        checkEq("grow flag", 1, growHit);
        checkEq("grow no shrink", 0, shrinkHit);
        setRand(10'h3a5, 10'h2c8);
        pulseFrame();
        checkEq("grow size", 5, playerSize);
        setPlayer(10'd1000, 10'd1000);
        setDraw(10'd421, 10'd200);
        cycle(1'b0);
        checkEq("grow new spot", 1, dotPixel[2]);
        setDraw(10'd17, 10'd58);
        cycle(1'b0);
        checkEq("grow old spot", 0, dotPixel[2]);

        // 400 masks down to 144
        testName = "shrink clamp";
        setRand(10'd500, 10'd400);
        hitUntilSize(8, 1);
        setPlayer(refX[8], refY[8]);
        repeat (2) pulseFrame();
        checkEq("shrink floor", 1, playerSize);

        testName = "grow clamp";
        setRand(10'd300, 10'd200);
        hitUntilSize(3, 10);
        setPlayer(refX[3], refY[3]);
        repeat (2) pulseFrame();
        checkEq("grow ceiling", 10, playerSize);

        // park dot 9 next to dot 3, then cover both
        testName = "priority";
        setPlayer(10'd300, 10'd99);
        setRand(10'd306, 10'd200);
        pulseFrame();
        setPlayer(10'd303, 10'd200);
        cycle(1'b0);
        checkEq("priority grow flag", 1, growHit);
        checkEq("priority shrink flag", 1, shrinkHit);
        setRand(10'd100, 10'd250);
        pulseFrame();
        checkEq("priority size", 10, playerSize);
        setPlayer(10'd1000, 10'd1000);
        setDraw(10'd100, 10'd250);
        cycle(1'b0);
        checkEq("priority dot 3", 1, dotPixel[3]);
        checkEq("priority dot 9", 1, dotPixel[9]);

        testName = "random sweep";
        for (int n = 0; n < 400; n++)
        begin
            k = $urandom_range(15, 0);
            if ($urandom_range(1, 0) == 1)
            begin
                setPlayer(jitter(refX[k]), jitter(refY[k]));
            end
            else
            begin
                setPlayer(10'($urandom_range(1023, 0)), 10'($urandom_range(1023, 0)));
            end
            k = $urandom_range(15, 0);
            setDraw(jitter(refX[k]), jitter(refY[k]));
            setRand(10'($urandom_range(1023, 0)), 10'($urandom_range(1023, 0)));
            cycle($urandom_range(3, 0) == 0);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== src.f ====
screenPkg.sv
dotPkg.sv
collisionScan.sv
dotField.sv
dotRenderer.sv
foodDots.sv
foodDotsTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the food dot testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f src.f \
    --top-module foodDotsTb \
    -o foodDotsSim

./obj_dir/foodDotsSim
